// File: run.sh
#!/bin/sh
# Compile the reservation station testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -Wno-fatal -f src.f --top-module rs_tb -o rs_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/rs_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

# Pass only when the testbench printed its pass line
if echo "$output" | grep -qx "No errors"; then
	exit 0
fi
exit 1

// File: source/priority_selector.sv
/* Lowest-index one-hot grant over a request vector.
   Serves both entry allocation and issue selection in the station. */

`timescale 1ns/1ps

module priority_selector #(
	parameter int WIDTH = rs_cfg_pkg::RS_SIZE
) (
	input  logic [WIDTH-1:0] req,
	input  logic             en,
	output logic [WIDTH-1:0] gnt
);

	logic [WIDTH-1:0] lowest;   // Lowest set bit of req

	// Two's complement trick isolates the lowest set request
	assign lowest = req & (~req + 1'b1);

	always_comb
	begin
		if (en)
			gnt = lowest;
		else
			gnt = '0;         // Disabled, nobody wins
	end

endmodule

// File: source/rs.sv
/* Reservation station top: allocates rename dispatches into free slots, wakes them
   from two CDB ports, and issues one ready slot per cycle to the functional units. */

`timescale 1ns/1ps

module rs (
	input  logic                             clock,
	input  logic                             reset,

	// From rename
	input  logic                             load,           // Dispatch strobe
	input  rs_types_pkg::dispatch_t          dispatch,

	// Result broadcast
	input  rs_types_pkg::cdb_t               cdb1,
	input  rs_types_pkg::cdb_t               cdb2,

	// Unit availability levels
	input  logic                             mult_available,
	input  logic                             adder_available,
	input  logic                             memory_available,

	// To the units and rename
	output rs_types_pkg::issue_t             issue,
	output logic                             full,
	output logic [rs_cfg_pkg::COUNT_W-1:0]   free_count
);

	import rs_cfg_pkg::*;
	import rs_types_pkg::*;

	logic [RS_SIZE-1:0]   free_vec;        // Slot is empty
	logic [RS_SIZE-1:0]   ready_vec;       // Slot can issue now
	logic [RS_SIZE-1:0]   alloc_gnt;       // One-hot target of this dispatch
	logic [RS_SIZE-1:0]   issue_gnt;       // One-hot issuing slot
	issue_t [RS_SIZE-1:0] payload;
	fu_sel_e              fu_dec;
	logic [OP_W-1:0]      op_class;
	logic                 load_accepted;
	logic                 issued;

	////////////////////////////////
	// Functional unit decode
	////////////////////////////////
	assign op_class = {dispatch.op_type[OP_W-1:3], 3'b000};

	always_comb
	begin
		if ((op_class == OP_CLASS_INT) && (dispatch.alu_func == ALU_MULQ))
			fu_dec = FU_MULT;
		else if ((op_class == OP_CLASS_MEM_A) || (op_class == OP_CLASS_MEM_L) ||
		         (op_class == OP_CLASS_MEM_S))
			fu_dec = FU_MEMORY;
		else
			fu_dec = FU_ADDER;      // All remaining integer work
	end

	////////////////////////////////
	// Entry array
	////////////////////////////////
	for (genvar i = 0; i < RS_SIZE; i++)
	begin : g_entry
		rs_entry entry_inst (
			.clock            (clock),
			.reset            (reset),
			.alloc            (alloc_gnt[i]),
			.dispatch         (dispatch),
			.fu               (fu_dec),
			.cdb1             (cdb1),
			.cdb2             (cdb2),
			.mult_available   (mult_available),
			.adder_available  (adder_available),
			.memory_available (memory_available),
			.take             (issue_gnt[i]),
			.free             (free_vec[i]),
			.ready            (ready_vec[i]),
			.payload          (payload[i])
		);
	end

	// Lowest free slot gets the dispatch, nothing when all are busy
	priority_selector #(.WIDTH(RS_SIZE)) alloc_sel (
		.req (free_vec),
		.en  (load),
		.gnt (alloc_gnt)
	);

	// Lowest ready slot issues, no stall from the units
	priority_selector #(.WIDTH(RS_SIZE)) issue_sel (
		.req (ready_vec),
		.en  (1'b1),
		.gnt (issue_gnt)
	);

	////////////////////////////////
	// Occupancy
	////////////////////////////////
	assign load_accepted = |alloc_gnt;
	assign issued        = |issue_gnt;

	rs_occupancy_counter counter_inst (
		.clock      (clock),
		.reset      (reset),
		.inc        (load_accepted),
		.dec        (issued),
		.free_count (free_count),
		.full       (full)
	);

	////////////////////////////////
	// Issue mux
	////////////////////////////////
	// Grant is one-hot, so at most one slot passes
	always_comb
	begin
		issue = '0;                  // Idle cycle drives zeros
		for (int i = 0; i < RS_SIZE; i++)
		begin
			if (issue_gnt[i])
				issue = payload[i];
		end
	end

endmodule

// File: source/rs_cfg_pkg.sv
/* Sizes and field widths of the reservation station and the core around it.
   Modules pull these in with a wildcard import. */

package rs_cfg_pkg;

	////////////////////////////////
	// Station and core sizes
	////////////////////////////////
	localparam int RS_SIZE  = 8;                      // Station entries
	localparam int PRN_SIZE = 64;                     // Physical registers
	localparam int PRN_W    = $clog2(PRN_SIZE);       // Tag width
	localparam int ROB_SIZE = 32;                     // Reorder buffer entries
	localparam int ROB_W    = $clog2(ROB_SIZE);       // ROB index width
	localparam int DATA_W   = 64;                     // Operand word
	localparam int OP_W     = 6;                      // Op type field
	localparam int COUNT_W  = $clog2(RS_SIZE) + 1;    // Holds 0..RS_SIZE

	////////////////////////////////
	// Op type classes
	////////////////////////////////
	// Class is the op type with its low three bits cleared
	localparam logic [OP_W-1:0] OP_CLASS_MEM_A = 6'h08;  // Load address forms
	localparam logic [OP_W-1:0] OP_CLASS_INT   = 6'h10;  // Integer ops, incl. multiply
	localparam logic [OP_W-1:0] OP_CLASS_MEM_L = 6'h20;  // Loads
	localparam logic [OP_W-1:0] OP_CLASS_MEM_S = 6'h28;  // Stores

endpackage

// File: source/rs_entry.sv
/* One reservation station slot: holds an instruction until both operands are values,
   snoops two CDB ports, and offers itself for issue when its unit is free. */

`timescale 1ns/1ps

module rs_entry (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    alloc,             // One-hot share of allocation grant
	input  rs_types_pkg::dispatch_t dispatch,
	input  rs_types_pkg::fu_sel_e   fu,                // Decoded unit for this dispatch
	input  rs_types_pkg::cdb_t      cdb1,
	input  rs_types_pkg::cdb_t      cdb2,
	input  logic                    mult_available,
	input  logic                    adder_available,
	input  logic                    memory_available,
	input  logic                    take,              // Issue grant for this slot
	output logic                    free,
	output logic                    ready,
	output rs_types_pkg::issue_t    payload
);

	import rs_cfg_pkg::*;
	import rs_types_pkg::*;

	entry_state_e     state;
	entry_state_e     state_next;
	operand_t         opa;            // Held operands
	operand_t         opb;
	operand_t         opa_next;       // After this cycle's CDB snoop
	operand_t         opb_next;
	logic [PRN_W-1:0] dest_tag;
	logic [ROB_W-1:0] rob_idx;
	logic [OP_W-1:0]  op_type;
	fu_sel_e          fu_held;
	logic             unit_available;
	logic             capture;        // Operand registers load this cycle

	// Replace a pending tag with a matching broadcast value
	function automatic operand_t wakeup(input operand_t op, input cdb_t c1, input cdb_t c2);
		operand_t result;
		result = op;
		if (!op.valid && c1.valid && (c1.tag == op.value[PRN_W-1:0]))
		begin
			result.value = c1.value;
			result.valid = 1'b1;
		end
		else if (!op.valid && c2.valid && (c2.tag == op.value[PRN_W-1:0]))
		begin
			result.value = c2.value;
			result.valid = 1'b1;
		end
		return result;
	endfunction

	////////////////////////////////
	// Operand wakeup
	////////////////////////////////
	// Empty slot snoops the incoming dispatch so a same-cycle broadcast is not lost
	assign opa_next = wakeup((state == ST_EMPTY) ? dispatch.opa : opa, cdb1, cdb2);
	assign opb_next = wakeup((state == ST_EMPTY) ? dispatch.opb : opb, cdb1, cdb2);
	assign capture  = ((state == ST_EMPTY) && alloc) || (state == ST_WAITING);

	////////////////////////////////
	// State machine
	////////////////////////////////
	always_comb
	begin
		state_next = state;
		case (state)
			ST_EMPTY:
				if (alloc)
					state_next = (opa_next.valid && opb_next.valid) ? ST_READY : ST_WAITING;
			ST_WAITING:
				if (opa_next.valid && opb_next.valid)
					state_next = ST_READY;
			ST_READY:
				if (take)
					state_next = ST_EMPTY;   // Leaves on the issue edge
			default:
				state_next = ST_EMPTY;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			state <= ST_EMPTY;
		else
			state <= state_next;
	end

	// Instruction fields
	always_ff @(posedge clock)
	begin
		if ((state == ST_EMPTY) && alloc)
		begin
			dest_tag <= dispatch.dest_tag;
			rob_idx  <= dispatch.rob_idx;
			op_type  <= dispatch.op_type;
			fu_held  <= fu;
		end
		if (capture)
		begin
			opa <= opa_next;
			opb <= opb_next;
		end
	end

	////////////////////////////////
	// Issue side
	////////////////////////////////
	always_comb
	begin
		case (fu_held)
			FU_MULT:   unit_available = mult_available;
			FU_MEMORY: unit_available = memory_available;
			default:   unit_available = adder_available;
		endcase
	end

	assign free  = (state == ST_EMPTY);
	assign ready = (state == ST_READY) && unit_available;

	always_comb
	begin
		payload.valid    = ready;
		payload.opa      = opa.value;
		payload.opb      = opb.value;
		payload.dest_tag = dest_tag;
		payload.rob_idx  = rob_idx;
		payload.op_type  = op_type;
		payload.fu       = fu_held;
	end

endmodule

// File: source/rs_occupancy_counter.sv
/* Occupied-entry count for the station, with the free count and full flag
   that rename watches before sending the next instruction. */

`timescale 1ns/1ps

module rs_occupancy_counter (
	input  logic                           clock,
	input  logic                           reset,
	input  logic                           inc,          // Accepted load
	input  logic                           dec,          // Issue
	output logic [rs_cfg_pkg::COUNT_W-1:0] free_count,
	output logic                           full
);

	import rs_cfg_pkg::*;

	logic [COUNT_W-1:0] count;
	logic [COUNT_W-1:0] count_next;

	// Load and issue together leave the count alone
	always_comb
	begin
		count_next = count;
		if (inc && !dec)
			count_next = count + 1'b1;
		else if (dec && !inc)
			count_next = count - 1'b1;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			count <= '0;
			full  <= 1'b0;
		end
		else
		begin
			count <= count_next;
			full  <= (count_next == COUNT_W'(RS_SIZE));   // Tracks the count exactly
		end
	end

	assign free_count = COUNT_W'(RS_SIZE) - count;

endmodule

// File: source/rs_types_pkg.sv
/* Bundles exchanged between rename, the station, the CDB and the functional units,
   plus the unit select and entry state encodings. */

package rs_types_pkg;

	import rs_cfg_pkg::*;

	////////////////////////////////
	// Encodings
	////////////////////////////////
	typedef enum logic [1:0] {
		FU_ADDER  = 2'd0,
		FU_MULT   = 2'd1,
		FU_MEMORY = 2'd2
	} fu_sel_e;

	// ALU function codes, only multiply steers the unit choice
	typedef enum logic [4:0] {
		ALU_ADDQ  = 5'h00,
		ALU_SUBQ  = 5'h01,
		ALU_AND   = 5'h02,
		ALU_BIS   = 5'h04,
		ALU_XOR   = 5'h06,
		ALU_SLL   = 5'h09,
		ALU_MULQ  = 5'h0b,
		ALU_CMPEQ = 5'h0c
	} alu_func_e;

	typedef enum logic [1:0] {
		ST_EMPTY   = 2'd0,
		ST_WAITING = 2'd1,
		ST_READY   = 2'd2
	} entry_state_e;

	////////////////////////////////
	// Bundles
	////////////////////////////////
	// With valid low, value[PRN_W-1:0] is the tag being waited on
	typedef struct packed {
		logic [DATA_W-1:0] value;
		logic              valid;
	} operand_t;

	typedef struct packed {
		logic [PRN_W-1:0] dest_tag;
		logic [ROB_W-1:0] rob_idx;
		logic [OP_W-1:0]  op_type;
		alu_func_e        alu_func;
		operand_t         opa;
		operand_t         opb;
	} dispatch_t;

	typedef struct packed {
		logic              valid;
		logic [PRN_W-1:0]  tag;
		logic [DATA_W-1:0] value;
	} cdb_t;

	typedef struct packed {
		logic              valid;
		logic [DATA_W-1:0] opa;
		logic [DATA_W-1:0] opb;
		logic [PRN_W-1:0]  dest_tag;
		logic [ROB_W-1:0]  rob_idx;
		logic [OP_W-1:0]   op_type;
		fu_sel_e           fu;
	} issue_t;

endpackage

// File: src.f
source/rs_cfg_pkg.sv
source/rs_types_pkg.sv
source/priority_selector.sv
source/rs_entry.sv
source/rs_occupancy_counter.sv
source/rs.sv
verification/rs_sva.sv
verification/rs_tb.sv

// File: verification/rs_sva.sv
/* Concurrent checks on issue selection, unit gating and occupancy,
   attached to the station top level with bind. */

`timescale 1ns/1ps

module rs_sva (
	input logic                           clock,
	input logic                           reset,
	input logic [rs_cfg_pkg::RS_SIZE-1:0] issue_gnt,
	input logic [rs_cfg_pkg::RS_SIZE-1:0] free_vec,
	input rs_types_pkg::issue_t           issue,
	input logic                           mult_available,
	input logic                           adder_available,
	input logic                           memory_available,
	input logic                           full,
	input logic [rs_cfg_pkg::COUNT_W-1:0] free_count
);

	import rs_cfg_pkg::*;
	import rs_types_pkg::*;

	logic unit_up;      // Level of the unit the issue targets
	int   occupied;     // Entries not free

	always_comb
	begin
		case (issue.fu)
			FU_MULT:   unit_up = mult_available;
			FU_MEMORY: unit_up = memory_available;
			default:   unit_up = adder_available;
		endcase
	end

	assign occupied = $countones(~free_vec);

	////////////////////////////////
	// Properties
	////////////////////////////////
	issue_onehot: assert property (@(posedge clock) disable iff (reset) $onehot0(issue_gnt))
		else $error("issue grant selects more than one entry");

	issue_unit_gated: assert property (@(posedge clock) disable iff (reset)
		issue.valid |-> unit_up)
		else $error("issue valid while its unit is unavailable");

	// Counter and entry array agree once the edge has settled
	occupancy_match: assert property (@(posedge clock) disable iff (reset)
		1'b1 |=> (int'(free_count) + occupied == RS_SIZE))
		else $error("free count disagrees with occupied entries");

	full_needs_no_free: assert property (@(posedge clock) disable iff (reset)
		$rose(full) |-> (free_count == '0))
		else $error("full raised with free entries left");

endmodule

bind rs rs_sva rs_sva_inst (
	.clock            (clock),
	.reset            (reset),
	.issue_gnt        (issue_gnt),
	.free_vec         (free_vec),
	.issue            (issue),
	.mult_available   (mult_available),
	.adder_available  (adder_available),
	.memory_available (memory_available),
	.full             (full),
	.free_count       (free_count)
);

// File: verification/rs_tb.sv
/* Testbench for the reservation station: directed and random dispatch traffic against
   a reference queue of outstanding instructions, with every issue checked. */

`timescale 1ns/1ps

module rs_tb;

	import rs_cfg_pkg::*;
	import rs_types_pkg::*;

	localparam int SEED        = 68288;
	localparam int NUM_RANDOM  = 200;                            // Random run length
	localparam int NUM_INSTR   = 240;                            // Random plus directed
	localparam int WATCHDOG_NS = 3 * NUM_INSTR * 40 + 16 * 40;

	// Model record holding the dispatch as it stands after CDB snooping
	typedef struct packed {
		dispatch_t d;
		fu_sel_e   fu;
	} model_entry_t;

	logic               clock;
	logic               reset;
	logic               load;
	dispatch_t          dispatch;
	cdb_t               cdb1;
	cdb_t               cdb2;
	logic               mult_available;
	logic               adder_available;
	logic               memory_available;
	issue_t             issue;
	logic               full;
	logic [COUNT_W-1:0] free_count;

	// Next cycle's inputs for the falling edge
	logic               nxt_load;
	dispatch_t          nxt_disp;
	cdb_t               nxt_cdb1;
	cdb_t               nxt_cdb2;
	logic [2:0]         nxt_avail;          // {memory, adder, mult}

	model_entry_t       outstanding[$];     // Queue size doubles as mirror count
	int                 errors;

	rs rs_inst (
		.clock            (clock),
		.reset            (reset),
		.load             (load),
		.dispatch         (dispatch),
		.cdb1             (cdb1),
		.cdb2             (cdb2),
		.mult_available   (mult_available),
		.adder_available  (adder_available),
		.memory_available (memory_available),
		.issue            (issue),
		.full             (full),
		.free_count       (free_count)
	);

	always #20 clock = ~clock;

	////////////////////////////////
	// Check helpers
	////////////////////////////////
	task automatic expect_equal(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		assert (got === exp)
		else
		begin
			errors++;
			$display("FAIL %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic expect_true(input logic cond, input string what);
		assert (cond)
		else
		begin
			errors++;
			$display("FAIL: %s", what);
		end
	endtask

	////////////////////////////////
	// Reference model
	////////////////////////////////
	// Unit from the op class with multiply only inside the integer class
	function automatic fu_sel_e expected_unit(input logic [OP_W-1:0] op, input alu_func_e func);
		logic [OP_W-1:0] cls;
		cls = op & 6'h38;
		if ((cls == 6'h10) && (func == ALU_MULQ))
			return FU_MULT;
		if ((cls == 6'h08) || (cls == 6'h20) || (cls == 6'h28))
			return FU_MEMORY;
		return FU_ADDER;
	endfunction

	function automatic logic unit_up(input fu_sel_e fu);
		case (fu)
			FU_MULT:   return mult_available;
			FU_MEMORY: return memory_available;
			default:   return adder_available;
		endcase
	endfunction

	function automatic int find_tag(input logic [PRN_W-1:0] tag);
		foreach (outstanding[i])
			if (outstanding[i].d.dest_tag == tag)
				return i;
		return -1;                                   // Not outstanding
	endfunction

	// A waiting operand takes a broadcast carrying its tag
	function automatic operand_t snoop_operand(input operand_t op);
		operand_t r;
		r = op;
		if (!r.valid && cdb1.valid && (cdb1.tag == op.value[PRN_W-1:0]))
		begin
			r.value = cdb1.value;
			r.valid = 1'b1;
		end
		if (!r.valid && cdb2.valid && (cdb2.tag == op.value[PRN_W-1:0]))
		begin
			r.value = cdb2.value;
			r.valid = 1'b1;
		end
		return r;
	endfunction

	// Apply inputs at the falling edge, check settled outputs, then step the model
	// to what the next rising edge stores
	task automatic run_cycle();
		int           idx;
		logic         accept;
		model_entry_t e;
		@(negedge clock);
		load     = nxt_load;
		dispatch = nxt_disp;
		cdb1     = nxt_cdb1;
		cdb2     = nxt_cdb2;
		{memory_available, adder_available, mult_available} = nxt_avail;
		#5;
		expect_equal("full", full, outstanding.size() == RS_SIZE);
		expect_equal("free_count", free_count, RS_SIZE - outstanding.size());
		accept = load && (outstanding.size() < RS_SIZE);    // Occupancy before this issue
		if (issue.valid)
		begin
			idx = find_tag(issue.dest_tag);
			expect_true(idx >= 0, "issued a dest tag that is not outstanding");
			if (idx >= 0)
			begin
				e = outstanding[idx];
				expect_true(e.d.opa.valid && e.d.opb.valid, "issued before operands arrived");
				expect_true(unit_up(e.fu), "issued to a unit that is not available");
				expect_equal("issue.opa", issue.opa, e.d.opa.value);
				expect_equal("issue.opb", issue.opb, e.d.opb.value);
				expect_equal("issue.rob_idx", issue.rob_idx, e.d.rob_idx);
				expect_equal("issue.op_type", issue.op_type, e.d.op_type);
				expect_equal("issue.fu", issue.fu, e.fu);
				outstanding.delete(idx);
			end
		end
		else
		begin
			// Idle issue port carries zeros
			expect_equal("issue.opa", issue.opa, '0);
			expect_equal("issue.opb", issue.opb, '0);
			expect_equal("issue.dest_tag", issue.dest_tag, '0);
		end
		if (accept)
		begin
			e.d  = dispatch;
			e.fu = expected_unit(dispatch.op_type, dispatch.alu_func);
			outstanding.push_back(e);
		end
		foreach (outstanding[i])
		begin
			e       = outstanding[i];
			e.d.opa = snoop_operand(e.d.opa);          // Same-cycle dispatch included
			e.d.opb = snoop_operand(e.d.opb);
			outstanding[i] = e;
		end
		nxt_load = 1'b0;
		nxt_cdb1 = '0;
		nxt_cdb2 = '0;
	endtask

	////////////////////////////////
	// Stimulus helpers
	////////////////////////////////
	function automatic operand_t make_operand(input logic valid, input logic [DATA_W-1:0] value);
		operand_t r;
		r.valid = valid;
		r.value = value;                             // Tag in low bits when not valid
		return r;
	endfunction

	function automatic operand_t rand_operand();
		if ($urandom_range(3, 0) == 0)
			return make_operand(1'b0, DATA_W'($urandom_range(PRN_SIZE - 1, 0)));
		return make_operand(1'b1, {$urandom, $urandom});
	endfunction

	function automatic logic [OP_W-1:0] rand_op();
		case ($urandom_range(6, 0))
			0:       return 6'h00;
			1:       return 6'h10;
			2:       return 6'h13;
			3:       return 6'h0c;                   // Memory classes
			4:       return 6'h21;
			5:       return 6'h2b;
			default: return 6'h18;
		endcase
	endfunction

	function automatic alu_func_e rand_func();
		case ($urandom_range(2, 0))
			0:       return ALU_MULQ;
			1:       return ALU_XOR;
			default: return ALU_ADDQ;
		endcase
	endfunction

	function automatic logic [PRN_W-1:0] unused_dest();
		logic [PRN_W-1:0] t;
		t = PRN_W'($urandom_range(PRN_SIZE - 1, 0));
		while (find_tag(t) >= 0)
			t = t + 1'b1;                            // Wraps over the tag space
		return t;
	endfunction

	// Finds a tag some outstanding operand still waits on
	function automatic logic pick_waiting(output logic [PRN_W-1:0] tag);
		int           n;
		int           k;
		model_entry_t e;
		n   = outstanding.size();
		tag = '0;
		if (n == 0)
			return 1'b0;
		k = $urandom_range(n - 1, 0);
		for (int i = 0; i < n; i++)
		begin
			e = outstanding[(k + i) % n];
			if (!e.d.opa.valid)
			begin
				tag = e.d.opa.value[PRN_W-1:0];
				return 1'b1;
			end
			if (!e.d.opb.valid)
			begin
				tag = e.d.opb.value[PRN_W-1:0];
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	task automatic stage_dispatch(input logic [PRN_W-1:0] dest, input logic [OP_W-1:0] op,
		input alu_func_e func, input operand_t a, input operand_t b);
		nxt_load          = 1'b1;
		nxt_disp.dest_tag = dest;
		nxt_disp.rob_idx  = ROB_W'($urandom);
		nxt_disp.op_type  = op;
		nxt_disp.alu_func = func;
		nxt_disp.opa      = a;
		nxt_disp.opb      = b;
	endtask

	task automatic stage_cdb(input int port, input logic [PRN_W-1:0] tag);
		cdb_t c;
		c.valid = 1'b1;
		c.tag   = tag;
		c.value = {$urandom, $urandom};
		if (port == 1)
			nxt_cdb1 = c;
		else
			nxt_cdb2 = c;
	endtask

	// All units up and one waited tag per cycle until the station empties or the limit hits
	task automatic drain(input int limit);
		logic [PRN_W-1:0] tag;
		int               n;
		nxt_avail = 3'b111;
		n         = 0;
		while ((outstanding.size() != 0) && (n < limit))
		begin
			if (pick_waiting(tag))
				stage_cdb(1, tag);
			run_cycle();
			n++;
		end
		expect_true(outstanding.size() == 0, "instructions still held after the drain limit");
	endtask

	////////////////////////////////
	// Tests
	////////////////////////////////
	task automatic ready_operands();
		for (int i = 0; i < 3; i++)
		begin
			stage_dispatch(PRN_W'(10 + i), 6'h00, ALU_ADDQ, make_operand(1'b1, {$urandom, $urandom}),
				make_operand(1'b1, {$urandom, $urandom}));
			run_cycle();
		end
		drain(20);
	endtask

	task automatic cdb_wakeup();
		stage_dispatch(6'd20, 6'h01, ALU_SUBQ, make_operand(1'b0, 64'd5),
			make_operand(1'b1, {$urandom, $urandom}));
		run_cycle();
		stage_cdb(2, 6'd5);                          // Broadcast on the second port a cycle later
		run_cycle();
		stage_dispatch(6'd21, 6'h02, ALU_XOR, make_operand(1'b1, {$urandom, $urandom}),
			make_operand(1'b0, 64'd6));
		stage_cdb(2, 6'd6);                          // Same cycle as the dispatch
		run_cycle();
		stage_dispatch(6'd22, 6'h00, ALU_ADDQ, make_operand(1'b0, 64'd7), make_operand(1'b0, 64'd8));
		stage_cdb(1, 6'd7);
		stage_cdb(2, 6'd8);
		run_cycle();
		drain(20);
	endtask

	task automatic fill_to_full();
		for (int i = 0; i < RS_SIZE; i++)
		begin
			stage_dispatch(PRN_W'(30 + i), 6'h00, ALU_ADDQ, make_operand(1'b0, DATA_W'(40 + i)),
				make_operand(1'b1, {$urandom, $urandom}));
			run_cycle();
		end
		// Ready at once if it were stored, so any issue of tag 50 is caught
		stage_dispatch(6'd50, 6'h00, ALU_ADDQ, make_operand(1'b1, 64'h1), make_operand(1'b1, 64'h2));
		run_cycle();
		expect_true(full, "station not full after every entry was loaded");
		drain(40);
		repeat (3) run_cycle();
	endtask

	task automatic unit_gating();
		nxt_avail = 3'b110;                          // Multiplier busy
		stage_dispatch(6'd55, 6'h10, ALU_MULQ, make_operand(1'b1, {$urandom, $urandom}),
			make_operand(1'b1, {$urandom, $urandom}));
		run_cycle();
		stage_dispatch(6'd56, 6'h2a, ALU_ADDQ, make_operand(1'b1, 64'h3), make_operand(1'b1, 64'h4));
		run_cycle();
		stage_dispatch(6'd57, 6'h11, ALU_ADDQ, make_operand(1'b1, 64'h5), make_operand(1'b1, 64'h6));
		run_cycle();
		stage_dispatch(6'd58, 6'h08, ALU_XOR, make_operand(1'b1, 64'h7), make_operand(1'b1, 64'h8));
		run_cycle();
		repeat (4) run_cycle();
		expect_true(find_tag(6'd55) >= 0, "multiply issued while the multiplier was busy");
		drain(10);
	endtask

	task automatic random_traffic();
		logic [PRN_W-1:0] tag;
		int               accepted;
		accepted = 0;
		while (accepted < NUM_RANDOM)
		begin
			nxt_avail = {$urandom_range(3, 0) != 0, $urandom_range(3, 0) != 0,
				$urandom_range(3, 0) != 0};
			if (pick_waiting(tag) && ($urandom_range(3, 0) != 0))
				stage_cdb(1, tag);
			if ($urandom_range(3, 0) != 0)
			begin
				stage_dispatch(unused_dest(), rand_op(), rand_func(), rand_operand(), rand_operand());
				tag = nxt_disp.opb.value[PRN_W-1:0];
				if (!nxt_disp.opb.valid && ($urandom_range(1, 0) == 1) &&
				    !(nxt_cdb1.valid && (nxt_cdb1.tag == tag)))
					stage_cdb(2, tag);           // Wake the new dispatch in its own cycle
				if (outstanding.size() < RS_SIZE)
					accepted++;
			end
			run_cycle();
		end
		drain(100);
		run_cycle();
		expect_equal("free_count", free_count, RS_SIZE);
	endtask

	initial
	begin
		void'($urandom(SEED));
		errors           = 0;
		clock            = 1'b0;
		reset            = 1'b1;
		load             = 1'b0;
		dispatch         = '0;
		cdb1             = '0;
		cdb2             = '0;
		mult_available   = 1'b1;
		adder_available  = 1'b1;
		memory_available = 1'b1;
		nxt_load         = 1'b0;
		nxt_disp         = '0;
		nxt_cdb1         = '0;
		nxt_cdb2         = '0;
		nxt_avail        = 3'b111;
		repeat (16) @(negedge clock);
		reset = 1'b0;
		run_cycle();
		expect_equal("issue.valid", issue.valid, 1'b0);
		ready_operands();
		cdb_wakeup();
		fill_to_full();
		unit_gating();
		random_traffic();
		$display("Run complete, %0d errors", errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(WATCHDOG_NS);
		errors++;
		$display("Timed out before the tests finished, %0d errors", errors);
		$display("Errors found");
		$finish;
	end

endmodule
